//--- rtl/fpu_cfg.svh
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// operand and tag widths
`define FPU_WORD_W 32
`define FPU_PREG_W 6
`define FPU_ROB_W 5

// cycles from accepted packet to pipe result
`define FPU_ADD_LAT 2
`define FPU_MUL_LAT 3

`endif

//--- rtl/fpu_pkg.sv
`include "fpu_cfg.svh"

package fpu_pkg;

    typedef enum logic [3:0] {
        UOP_NOP  = 4'd0,
        UOP_ADD  = 4'd1,
        UOP_SUB  = 4'd2,
        UOP_MUL  = 4'd3,
        UOP_LOAD = 4'd4,
        UOP_STOR = 4'd5,
        UOP_BR   = 4'd6,
        UOP_FADD = 4'd8,
        UOP_FSUB = 4'd9,
        UOP_FMUL = 4'd10
    } uop_e;

    typedef enum logic [1:0] {
        PENDING = 2'd0,
        DONE    = 2'd1,
        FAULT   = 2'd2
    } rob_status_e;

    // single precision fields
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] man;
    } fp_fields_t;

    typedef union packed {
        logic [`FPU_WORD_W-1:0] raw;
        fp_fields_t             f;
    } fp_word_u;

    typedef struct packed {
        logic [`FPU_PREG_W-1:0] preg;
        logic [`FPU_ROB_W-1:0]  rob_ptr;
    } fpu_tag_t;

    typedef struct packed {
        logic                   valid;
        uop_e                   uop;
        logic [`FPU_WORD_W-1:0] r1_val;
        logic [`FPU_WORD_W-1:0] r2_val;
        fpu_tag_t               tag;
    } exec_packet_t;

    typedef struct packed {
        logic     valid;
        fp_word_u a;
        fp_word_u b;
        fpu_tag_t tag;
    } fp_issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`FPU_WORD_W-1:0] value;
        fpu_tag_t               tag;
    } fp_result_t;

    typedef struct packed {
        logic                   en;
        logic [`FPU_PREG_W-1:0] index;
        logic [`FPU_WORD_W-1:0] data;
    } regfile_write_t;

    typedef struct packed {
        logic                  valid;
        logic [`FPU_ROB_W-1:0] ptr;
        rob_status_e           status;
    } rob_writeback_t;

endpackage

//--- rtl/fpu_decode.sv
module fpu_decode (
    input  logic                 clk_in,
    input  logic                 rst,
    input  logic                 flush,
    input  fpu_pkg::exec_packet_t insn_in,
    output logic                 ready_out,
    output fpu_pkg::fp_issue_t   add_issue,
    output fpu_pkg::fp_issue_t   mul_issue
);

    logic              is_fadd;
    logic              is_fsub;
    logic              is_fmul;
    logic              accept;
    logic              add_vld_q;
    logic              mul_vld_q;
    fpu_pkg::fp_word_u b_cond;
    fpu_pkg::fp_word_u a_q;
    fpu_pkg::fp_word_u b_q;
    fpu_pkg::fpu_tag_t tag_q;

    assign is_fadd = insn_in.uop == fpu_pkg::UOP_FADD;
    assign is_fsub = insn_in.uop == fpu_pkg::UOP_FSUB;
    assign is_fmul = insn_in.uop == fpu_pkg::UOP_FMUL;

    // multiply issued last cycle, so an add now would finish alongside it
    assign ready_out = ~mul_vld_q;
    assign accept    = insn_in.valid && ready_out && (is_fadd || is_fsub || is_fmul);

    // subtract is add with the sign of r2 flipped
    always_comb begin
        b_cond.raw = insn_in.r2_val;
        if (is_fsub) begin
            b_cond.f.sign = ~b_cond.f.sign;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            add_vld_q <= 1'b0;
            mul_vld_q <= 1'b0;
        end else begin
            add_vld_q <= accept && (is_fadd || is_fsub);
            mul_vld_q <= accept && is_fmul;
        end
    end

    // one op per cycle, so both pipes share the operand register
    always_ff @(posedge clk_in) begin
        if (accept) begin
            a_q.raw <= insn_in.r1_val;
            b_q     <= b_cond;
            tag_q   <= insn_in.tag;
        end
    end

    assign add_issue = '{valid: add_vld_q, a: a_q, b: b_q, tag: tag_q};
    assign mul_issue = '{valid: mul_vld_q, a: a_q, b: b_q, tag: tag_q};

endmodule

//--- rtl/fp_add_pipe.sv
`include "fpu_cfg.svh"

module fp_add_pipe (
    input  logic                clk_in,
    input  logic                rst,
    input  logic                flush,
    input  fpu_pkg::fp_issue_t  issue,
    output fpu_pkg::fp_result_t res
);

    fpu_pkg::fp_word_u      op_big;
    fpu_pkg::fp_word_u      op_small;
    logic [23:0]            m_big;
    logic [23:0]            m_small;
    logic [23:0]            m_shift;
    logic [7:0]             exp_diff;
    logic                   s1_sign;
    logic [7:0]             s1_exp;
    logic [24:0]            s1_sum;
    logic [4:0]             lz;
    logic [23:0]            shifted;
    fpu_pkg::fp_word_u      norm;
    logic [`FPU_WORD_W-1:0] out_q;
    logic [`FPU_ADD_LAT-1:0] vld_pipe;
    fpu_pkg::fpu_tag_t      tag_pipe [`FPU_ADD_LAT];

    function automatic logic [4:0] lzc24(input logic [23:0] v);
        logic [4:0] n;
        n = 5'd24;
        for (int i = 0; i < 24; i++) begin
            if (v[i]) begin
                n = 5'(23 - i);
            end
        end
        return n;
    endfunction

    // stage 1: order by magnitude and align
    always_comb begin
        if (issue.b.raw[30:0] > issue.a.raw[30:0]) begin
            op_big   = issue.b;
            op_small = issue.a;
        end else begin
            op_big   = issue.a;
            op_small = issue.b;
        end
        // denormals read as zero
        m_big    = (op_big.f.exp != 8'd0) ? {1'b1, op_big.f.man} : 24'd0;
        m_small  = (op_small.f.exp != 8'd0) ? {1'b1, op_small.f.man} : 24'd0;
        exp_diff = op_big.f.exp - op_small.f.exp;
        m_shift  = (exp_diff > 8'd23) ? 24'd0 : m_small >> exp_diff;
    end

    always_ff @(posedge clk_in) begin
        s1_sign <= op_big.f.sign;
        s1_exp  <= op_big.f.exp;
        if (op_big.f.sign == op_small.f.sign) begin
            s1_sum <= {1'b0, m_big} + {1'b0, m_shift};
        end else begin
            s1_sum <= {1'b0, m_big} - {1'b0, m_shift};
        end
    end

    // stage 2: normalize, truncate
    always_comb begin
        lz       = lzc24(s1_sum[23:0]);
        shifted  = s1_sum[23:0] << lz;
        norm.raw = '0;
        if (s1_sum[24]) begin
            norm.f.sign = s1_sign;
            norm.f.exp  = s1_exp + 8'd1;
            norm.f.man  = s1_sum[23:1];
        end else if (s1_sum[23:0] != 24'd0 && s1_exp > {3'b0, lz}) begin
            norm.f.sign = s1_sign;
            norm.f.exp  = s1_exp - {3'b0, lz};
            norm.f.man  = shifted[22:0];
        end
        // cancellation or underflow stays +0
    end

    always_ff @(posedge clk_in) begin
        out_q <= norm.raw;
    end

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`FPU_ADD_LAT-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk_in) begin
        tag_pipe[0] <= issue.tag;
        for (int i = 1; i < `FPU_ADD_LAT; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign res = '{
        valid: vld_pipe[`FPU_ADD_LAT-1],
        value: out_q,
        tag:   tag_pipe[`FPU_ADD_LAT-1]
    };

endmodule

//--- rtl/fp_mul_pipe.sv
`include "fpu_cfg.svh"

module fp_mul_pipe (
    input  logic                clk_in,
    input  logic                rst,
    input  logic                flush,
    input  fpu_pkg::fp_issue_t  issue,
    output fpu_pkg::fp_result_t res
);

    logic                    s1_sign;
    logic signed [9:0]       s1_exp;
    logic                    s1_zero;
    logic [23:0]             s1_ma;
    logic [23:0]             s1_mb;
    logic                    s2_sign;
    logic signed [9:0]       s2_exp;
    logic                    s2_zero;
    logic [47:0]             s2_prod;
    logic signed [9:0]       e_norm;
    logic [22:0]             prod_man;
    fpu_pkg::fp_word_u       norm;
    logic [`FPU_WORD_W-1:0]  out_q;
    logic [`FPU_MUL_LAT-1:0] vld_pipe;
    fpu_pkg::fpu_tag_t       tag_pipe [`FPU_MUL_LAT];

    // stage 1: sign and biased exponent sum
    always_ff @(posedge clk_in) begin
        s1_sign <= issue.a.f.sign ^ issue.b.f.sign;
        s1_exp  <= $signed({2'b0, issue.a.f.exp}) + $signed({2'b0, issue.b.f.exp})
                   - 10'sd127;
        s1_zero <= (issue.a.f.exp == 8'd0) || (issue.b.f.exp == 8'd0);
        s1_ma   <= {1'b1, issue.a.f.man};
        s1_mb   <= {1'b1, issue.b.f.man};
    end

    // stage 2: mantissa product
    always_ff @(posedge clk_in) begin
        s2_sign <= s1_sign;
        s2_exp  <= s1_exp;
        s2_zero <= s1_zero;
        s2_prod <= {24'b0, s1_ma} * {24'b0, s1_mb};
    end

    // stage 3: product is in [1,4), so at most one bit of shift
    always_comb begin
        e_norm   = s2_exp + (s2_prod[47] ? 10'sd1 : 10'sd0);
        prod_man = s2_prod[47] ? s2_prod[46:24] : s2_prod[45:23];
        norm.raw = '0;
        if (!s2_zero && e_norm > 10'sd0) begin
            norm.f.sign = s2_sign;
            norm.f.exp  = e_norm[7:0];
            norm.f.man  = prod_man;
        end
    end

    always_ff @(posedge clk_in) begin
        out_q <= norm.raw;
    end

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`FPU_MUL_LAT-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk_in) begin
        tag_pipe[0] <= issue.tag;
        for (int i = 1; i < `FPU_MUL_LAT; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign res = '{
        valid: vld_pipe[`FPU_MUL_LAT-1],
        value: out_q,
        tag:   tag_pipe[`FPU_MUL_LAT-1]
    };

endmodule

//--- rtl/fpu_result.sv
module fpu_result (
    input  fpu_pkg::fp_result_t     add_res,
    input  fpu_pkg::fp_result_t     mul_res,
    output fpu_pkg::regfile_write_t reg_pkt_out,
    output fpu_pkg::rob_writeback_t writeback_out
);

    fpu_pkg::fp_result_t sel;

    // never both valid, decode spaces them out
    always_comb begin
        sel           = add_res.valid ? add_res : mul_res;
        reg_pkt_out   = '0;
        writeback_out = '0;
        if (sel.valid) begin
            reg_pkt_out.en       = 1'b1;
            reg_pkt_out.index    = sel.tag.preg;
            reg_pkt_out.data     = sel.value;
            writeback_out.valid  = 1'b1;
            writeback_out.ptr    = sel.tag.rob_ptr;
            writeback_out.status = fpu_pkg::DONE;
        end
    end

endmodule

//--- rtl/fpu_unit.sv
module fpu_unit (
    input  logic                    clk_in,
    input  logic                    rst,
    input  logic                    flush,
    input  fpu_pkg::exec_packet_t   insn_in,
    output logic                    ready_out,
    output fpu_pkg::regfile_write_t reg_pkt_out,
    output fpu_pkg::rob_writeback_t writeback_out
);

    fpu_pkg::fp_issue_t  add_issue;
    fpu_pkg::fp_issue_t  mul_issue;
    fpu_pkg::fp_result_t add_res;
    fpu_pkg::fp_result_t mul_res;

    fpu_decode fpu_decode_inst (
        .clk_in    (clk_in),
        .rst       (rst),
        .flush     (flush),
        .insn_in   (insn_in),
        .ready_out (ready_out),
        .add_issue (add_issue),
        .mul_issue (mul_issue)
    );

    fp_add_pipe fp_add_pipe_inst (
        .clk_in (clk_in),
        .rst    (rst),
        .flush  (flush),
        .issue  (add_issue),
        .res    (add_res)
    );

    fp_mul_pipe fp_mul_pipe_inst (
        .clk_in (clk_in),
        .rst    (rst),
        .flush  (flush),
        .issue  (mul_issue),
        .res    (mul_res)
    );

    fpu_result fpu_result_inst (
        .add_res       (add_res),
        .mul_res       (mul_res),
        .reg_pkt_out   (reg_pkt_out),
        .writeback_out (writeback_out)
    );

endmodule

//--- bench/fpu_unit_tb.sv
`include "fpu_cfg.svh"

module fpu_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int N_RAND          = 60;
    localparam int N_OPS           = N_RAND + 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_OPS * 10 + 50;

    typedef struct packed {
        logic [31:0]       due;
        logic [31:0]       value;
        fpu_pkg::fpu_tag_t tag;
    } expect_t;

    logic                    clk_in = 1'b0;
    logic                    rst;
    logic                    flush;
    fpu_pkg::exec_packet_t   insn_in;
    logic                    ready_out;
    fpu_pkg::regfile_write_t reg_pkt_out;
    fpu_pkg::rob_writeback_t writeback_out;

    logic [31:0] cyc = 32'd0;
    logic [31:0] lcg_state = 32'h37ab_e2d7;
    logic        mul_last = 1'b0;
    expect_t     model_q[$];

    fpu_unit fpu_unit_inst (
        .clk_in        (clk_in),
        .rst           (rst),
        .flush         (flush),
        .insn_in       (insn_in),
        .ready_out     (ready_out),
        .reg_pkt_out   (reg_pkt_out),
        .writeback_out (writeback_out)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cyc <= cyc + 32'd1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // halves in -8.0 .. 8.0, so every sum and product is exact
    function automatic real rand_operand();
        logic [31:0] r;
        r = next_rand();
        return ($itor(r[23:16] % 8'd33) - 16.0) / 2.0;
    endfunction

    // zero results come back as +0
    function automatic logic [31:0] fp_bits(input real r);
        logic [63:0] d;
        if (r == 0.0) begin
            return 32'h0;
        end
        // double rebiased to single, exact for these small values
        d = $realtobits(r);
        return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
    endfunction

    function automatic real single_to_real(input logic [31:0] w);
        if (w[30:23] == 8'd0) begin
            return 0.0;
        end
        return $bitstoreal({w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0});
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp_val, got_val);
        $display("Some tests failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic send(input fpu_pkg::uop_e uop, input logic valid, input real a,
                        input real b);
        logic [31:0] r;
        r = next_rand();
        @(posedge clk_in);
        insn_in <= '{valid: valid, uop: uop, r1_val: fp_bits(a),
                     r2_val: fp_bits(b), tag: '{preg: r[5:0], rob_ptr: r[12:8]}};
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_in);
            insn_in <= '0;
        end
    endtask

    // packet offered alongside the flush must be dropped too
    task automatic pulse_flush();
        @(posedge clk_in);
        flush   <= 1'b1;
        insn_in <= '{valid: 1'b1, uop: fpu_pkg::UOP_FADD, r1_val: fp_bits(1.0),
                     r2_val: fp_bits(2.0), tag: '0};
        @(posedge clk_in);
        flush   <= 1'b0;
        insn_in <= '0;
    endtask

    task automatic send_random();
        logic [31:0]   r;
        fpu_pkg::uop_e uop;
        logic          valid;
        r     = next_rand();
        valid = 1'b1;
        case (r[27:24] % 4'd6)
            4'd0: begin
                case (r[29:28])
                    2'd0: uop = fpu_pkg::UOP_ADD;
                    2'd1: uop = fpu_pkg::UOP_LOAD;
                    2'd2: uop = fpu_pkg::UOP_BR;
                    default: uop = fpu_pkg::UOP_MUL;
                endcase
            end
            4'd1: begin
                uop   = fpu_pkg::UOP_FADD;
                valid = 1'b0;
            end
            4'd2, 4'd3: uop = fpu_pkg::UOP_FADD;
            4'd4: uop = fpu_pkg::UOP_FSUB;
            default: uop = fpu_pkg::UOP_FMUL;
        endcase
        send(uop, valid, rand_operand(), rand_operand());
    endtask

    // reference model and checks, sampled mid-cycle while outputs are stable
    always @(negedge clk_in) begin : monitor
        expect_t head;
        logic    exp_valid;
        logic    accept;
        real     a;
        real     b;
        real     r;
        exp_valid = (model_q.size() != 0) && (model_q[0].due == cyc);
        head      = exp_valid ? model_q[0] : '0;
        chk_en: assert (reg_pkt_out.en == exp_valid)
            else report_mismatch("reg_pkt_out.en", 32'(exp_valid), 32'(reg_pkt_out.en));
        chk_wb_valid: assert (writeback_out.valid == exp_valid)
            else report_mismatch("writeback_out.valid", 32'(exp_valid),
                                 32'(writeback_out.valid));
        if (exp_valid) begin
            chk_index: assert (reg_pkt_out.index == head.tag.preg)
                else report_mismatch("reg_pkt_out.index", 32'(head.tag.preg),
                                     32'(reg_pkt_out.index));
            chk_data: assert (reg_pkt_out.data == head.value)
                else report_mismatch("reg_pkt_out.data", head.value, reg_pkt_out.data);
            chk_ptr: assert (writeback_out.ptr == head.tag.rob_ptr)
                else report_mismatch("writeback_out.ptr", 32'(head.tag.rob_ptr),
                                     32'(writeback_out.ptr));
            chk_status: assert (writeback_out.status == fpu_pkg::DONE)
                else report_mismatch("writeback_out.status", 32'(fpu_pkg::DONE),
                                     32'(writeback_out.status));
            void'(model_q.pop_front());
        end
        chk_ready: assert (ready_out == !mul_last)
            else report_mismatch("ready_out", 32'(!mul_last), 32'(ready_out));

        // what the coming edge does
        if (rst || flush) begin
            model_q.delete();
            mul_last = 1'b0;
        end else begin
            accept = insn_in.valid && !mul_last &&
                     (insn_in.uop == fpu_pkg::UOP_FADD || insn_in.uop == fpu_pkg::UOP_FSUB ||
                      insn_in.uop == fpu_pkg::UOP_FMUL);
            if (accept) begin
                a = single_to_real(insn_in.r1_val);
                b = single_to_real(insn_in.r2_val);
                if (insn_in.uop == fpu_pkg::UOP_FMUL) begin
                    r = a * b;
                    model_q.push_back('{due: cyc + 32'd1 + `FPU_MUL_LAT, value: fp_bits(r),
                                        tag: insn_in.tag});
                end else begin
                    r = (insn_in.uop == fpu_pkg::UOP_FSUB) ? a - b : a + b;
                    model_q.push_back('{due: cyc + 32'd1 + `FPU_ADD_LAT, value: fp_bits(r),
                                        tag: insn_in.tag});
                end
            end
            mul_last = accept && (insn_in.uop == fpu_pkg::UOP_FMUL);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Some tests failed");
        $fatal(1, "timeout: the run did not finish in time");
    end

    initial begin : stimulus
        rst     = 1'b1;
        flush   = 1'b0;
        insn_in = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst <= 1'b0;
        idle(4);

        // one of each, spaced out
        send(fpu_pkg::UOP_FADD, 1'b1, 1.5, 2.0);
        idle(4);
        send(fpu_pkg::UOP_FSUB, 1'b1, 3.0, 5.5);
        idle(4);
        send(fpu_pkg::UOP_FMUL, 1'b1, -2.5, 1.5);
        idle(5);

        for (int i = 0; i < N_RAND; i++) begin
            send_random();
        end
        idle(6);

        // subtract lands in the ready-low cycle and is dropped
        send(fpu_pkg::UOP_FADD, 1'b1, 4.0, -0.5);
        send(fpu_pkg::UOP_FMUL, 1'b1, 3.5, -2.0);
        send(fpu_pkg::UOP_FSUB, 1'b1, 1.0, 6.0);
        send(fpu_pkg::UOP_FADD, 1'b1, -7.5, 2.5);
        pulse_flush();
        idle(8);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/fpu_pkg.sv
rtl/fpu_decode.sv
rtl/fp_add_pipe.sv
rtl/fp_mul_pipe.sv
rtl/fpu_result.sv
rtl/fpu_unit.sv
bench/fpu_unit_tb.sv

//--- Makefile
# Verilator flow for the FPU execution unit

VERILATOR ?= verilator
TOP       ?= fpu_unit_tb
DUT_TOP   ?= fpu_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
